// ==== compile.f ====
rtl/bpi_bus_pkg.sv
rtl/bpi_cmd_pkg.sv
rtl/bpi_fifo.sv
rtl/bpi_cmd_parser.sv
rtl/bpi_sequencer.sv
rtl/bpi_status_reg.sv
rtl/bpi_ctrl.sv
tests/bpi_sequencer_asserts.sv
tests/bpi_checker.sv
tests/tb_bpi_ctrl.sv

// ==== rtl/bpi_bus_pkg.sv ====
package bpi_bus_pkg;

  typedef logic [15:0] word_t;    // Host and PROM data word
  typedef logic [22:0] addr_t;    // PROM word address
  typedef logic [6:0]  base_t;    // Upper address bits
  typedef logic [15:0] offset_t;  // Lower address bits

  typedef logic [1:0] bpi_op_t;
  localparam bpi_op_t BPI_OP_READ  = 2'b10;
  localparam bpi_op_t BPI_OP_WRITE = 2'b01;

  // One bus cycle toward the low-level port
  typedef struct packed {
    bpi_op_t op;
    addr_t   addr;
    word_t   data;
  } bpi_cycle_t;

  // Returned by the low-level port
  typedef struct packed {
    logic  busy;       // Bus cycle in progress
    logic  load_data;  // Read data valid
    word_t data;
  } bpi_resp_t;

endpackage

// ==== rtl/bpi_cmd_parser.sv ====
`timescale 1ns/10ps

module bpi_cmd_parser
(
  input  logic                   CLK,
  input  logic                   local_rst,
  input  logic                   enable,
  input  bpi_bus_pkg::word_t     fifo_data,
  input  logic                   fifo_empty,
  output logic                   fifo_rd,
  output bpi_cmd_pkg::seq_req_t  req,
  output logic                   req_valid,
  input  logic                   req_ready,
  input  logic                   seq_done,
  output logic                   clr_status,
  output logic                   idle
);
  import bpi_bus_pkg::*;
  import bpi_cmd_pkg::*;

  typedef enum logic [2:0] {P_IDLE, P_FETCH, P_EXTRA, P_ISSUE, P_WAIT} parse_state_t;

  parse_state_t state;
  usr_cmd_t     head_cmd;
  usr_cmd_t     cmd_q;
  base_t        arg_q;       // Base from a Load_Address word
  base_t        base_q;
  offset_t      offset_q;
  word_t        prog_data_q;

  assign head_cmd   = usr_cmd_t'(fifo_data[4:0]);
  assign fifo_rd    = (state == P_FETCH) || ((state == P_EXTRA) && !fifo_empty);
  assign clr_status = (state == P_FETCH) && (head_cmd == CMD_CLR_BPI_STATUS);
  assign req_valid  = (state == P_ISSUE);
  assign idle       = (state == P_IDLE);
  assign req        = '{cmd: cmd_q, addr: {base_q, offset_q}, data: prog_data_q};

  ////////////////////
  // Word decode FSM
  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      state    <= P_IDLE;
      cmd_q    <= CMD_NOOP;
      base_q   <= '0;
      offset_q <= '0;
    end
    else
    begin
      case (state)
        P_IDLE:
          if (enable && !fifo_empty)
            state <= P_FETCH;
        P_FETCH:
        begin
          cmd_q <= head_cmd;
          case (head_cmd)
            CMD_LOAD_ADDRESS,
            CMD_PROGRAM:         state <= P_EXTRA;   // Second word follows
            CMD_READ_1,
            CMD_READ_ARRAY,
            CMD_READ_STATUS_REG,
            CMD_BLOCK_ERASE:     state <= P_ISSUE;
            default:             state <= P_IDLE;    // NoOp, local clear, unknown
          endcase
        end
        P_EXTRA:
          if (!fifo_empty)
          begin
            if (cmd_q == CMD_LOAD_ADDRESS)
            begin
              base_q   <= arg_q;
              offset_q <= fifo_data;
              state    <= P_IDLE;
            end
            else
              state <= P_ISSUE;
          end
        P_ISSUE:
          if (req_ready)
            state <= P_WAIT;
        P_WAIT:
          if (seq_done)
          begin
            // Step through the array word by word
            if ((cmd_q == CMD_READ_1) || (cmd_q == CMD_PROGRAM))
              offset_q <= offset_q + 1'b1;
            state <= P_IDLE;
          end
        default: state <= P_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (state == P_FETCH)
      arg_q <= fifo_data[11:5];
    if ((state == P_EXTRA) && !fifo_empty)
      prog_data_q <= fifo_data;      // Load_Address leaves it unused
  end

endmodule

// ==== rtl/bpi_cmd_pkg.sv ====
package bpi_cmd_pkg;

  typedef logic [4:0] usr_cmd_t;

  // Host command codes
  localparam usr_cmd_t CMD_NOOP            = 5'h00;
  localparam usr_cmd_t CMD_READ_1          = 5'h02;
  localparam usr_cmd_t CMD_READ_ARRAY      = 5'h05;
  localparam usr_cmd_t CMD_READ_STATUS_REG = 5'h06;
  localparam usr_cmd_t CMD_BLOCK_ERASE     = 5'h0A;
  localparam usr_cmd_t CMD_PROGRAM         = 5'h0B;
  localparam usr_cmd_t CMD_LOAD_ADDRESS    = 5'h17;
  localparam usr_cmd_t CMD_CLR_BPI_STATUS  = 5'h1C;

  // PROM opcodes, written on the data bus
  localparam bpi_bus_pkg::word_t OPC_READ_ARRAY  = 16'h00FF;
  localparam bpi_bus_pkg::word_t OPC_READ_SR     = 16'h0070;
  localparam bpi_bus_pkg::word_t OPC_ERASE_SETUP = 16'h0020;
  localparam bpi_bus_pkg::word_t OPC_CONFIRM     = 16'h00D0;
  localparam bpi_bus_pkg::word_t OPC_PROGRAM     = 16'h0040;

  typedef enum logic {RD_ARRAY, RD_STATUS} read_mode_t;

  localparam logic [7:0] ERASE_ERR_MASK = 8'h2A;
  localparam logic [7:0] PROG_ERR_MASK  = 8'h1A;
  localparam int         SR_READY_BIT   = 7;    // P/E controller ready

  // Host status word bit positions
  localparam int ST_RBK_EMPTY = 15;
  localparam int ST_RBK_FULL  = 14;
  localparam int ST_RBK_RERR  = 13;
  localparam int ST_RBK_WERR  = 12;
  localparam int ST_CMD_EMPTY = 11;
  localparam int ST_CMD_FULL  = 10;
  localparam int ST_CMD_RERR  = 9;
  localparam int ST_CMD_WERR  = 8;

  // Block geometry
  localparam bpi_bus_pkg::addr_t PARAM_BLOCK_START = 23'h7F0000;
  localparam bpi_bus_pkg::addr_t PARAM_BLOCK_MASK  = 23'h7FC000;  // 16 KWord blocks
  localparam bpi_bus_pkg::addr_t MAIN_BLOCK_MASK   = 23'h7F0000;  // 64 KWord blocks
  localparam bpi_bus_pkg::addr_t BANK_MASK         = 23'h780000;

  typedef struct packed {
    usr_cmd_t            cmd;
    bpi_bus_pkg::addr_t  addr;
    bpi_bus_pkg::word_t  data;
  } seq_req_t;

endpackage

// ==== rtl/bpi_ctrl.sv ====
`timescale 1ns/10ps

module bpi_ctrl #(
  parameter int FIFO_AW = 11
)
(
  input  logic                    CLK,
  input  logic                    local_rst,
  input  bpi_bus_pkg::word_t      cmd_data,
  input  logic                    cmd_we,
  input  logic                    rbk_re,
  input  logic                    enbl,
  input  logic                    dsbl,
  output bpi_bus_pkg::word_t      rbk_data,
  output logic [FIFO_AW:0]        rbk_wrd_cnt,
  output bpi_bus_pkg::word_t      status,
  output logic                    active,
  output bpi_bus_pkg::bpi_cycle_t cycle,
  output logic                    execute,
  input  bpi_bus_pkg::bpi_resp_t  resp
);
  import bpi_bus_pkg::*;
  import bpi_cmd_pkg::*;

  word_t      cmd_head;
  logic       cmd_rd;
  logic       cmd_empty;
  logic       cmd_full;
  logic       cmd_wr_err;
  logic       cmd_rd_err;
  logic       rbk_wr;
  logic       rbk_empty;
  logic       rbk_full;
  logic       rbk_wr_err;
  logic       rbk_rd_err;
  seq_req_t   req;
  logic       req_valid;
  logic       req_ready;
  logic       seq_done;
  logic       clr_status;
  logic       parser_idle;
  logic       parse_en;
  logic [7:0] sr_byte;
  logic       sr_valid;

  ////////////////////
  // Parse enable and activity
  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      parse_en <= 1'b0;
      active   <= 1'b0;
    end
    else
    begin
      if (enbl)
        parse_en <= 1'b1;     // Enable has priority
      else if (dsbl)
        parse_en <= 1'b0;
      active <= !parser_idle;
    end
  end

  bpi_fifo #(.FIFO_AW(FIFO_AW)) cmd_fifo_i (
    .CLK       (CLK),
    .local_rst (local_rst),
    .wr        (cmd_we),
    .wdata     (cmd_data),
    .rd        (cmd_rd),
    .rdata     (cmd_head),
    .empty     (cmd_empty),
    .full      (cmd_full),
    .count     (),
    .wr_err    (cmd_wr_err),
    .rd_err    (cmd_rd_err)
  );

  bpi_fifo #(.FIFO_AW(FIFO_AW)) rbk_fifo_i (
    .CLK       (CLK),
    .local_rst (local_rst),
    .wr        (rbk_wr),
    .wdata     (resp.data),         // PROM read data straight in
    .rd        (rbk_re),
    .rdata     (rbk_data),
    .empty     (rbk_empty),
    .full      (rbk_full),
    .count     (rbk_wrd_cnt),
    .wr_err    (rbk_wr_err),
    .rd_err    (rbk_rd_err)
  );

  bpi_cmd_parser bpi_cmd_parser_i (
    .CLK        (CLK),
    .local_rst  (local_rst),
    .enable     (parse_en),
    .fifo_data  (cmd_head),
    .fifo_empty (cmd_empty),
    .fifo_rd    (cmd_rd),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .seq_done   (seq_done),
    .clr_status (clr_status),
    .idle       (parser_idle)
  );

  bpi_sequencer bpi_sequencer_i (
    .CLK       (CLK),
    .local_rst (local_rst),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .seq_done  (seq_done),
    .cycle     (cycle),
    .execute   (execute),
    .resp      (resp),
    .rbk_wr    (rbk_wr),
    .sr_byte   (sr_byte),
    .sr_valid  (sr_valid)
  );

  bpi_status_reg bpi_status_reg_i (
    .CLK        (CLK),
    .local_rst  (local_rst),
    .rbk_empty  (rbk_empty),
    .rbk_full   (rbk_full),
    .rbk_rd_err (rbk_rd_err),
    .rbk_wr_err (rbk_wr_err),
    .cmd_empty  (cmd_empty),
    .cmd_full   (cmd_full),
    .cmd_rd_err (cmd_rd_err),
    .cmd_wr_err (cmd_wr_err),
    .sr_byte    (sr_byte),
    .sr_valid   (sr_valid),
    .clr_status (clr_status),
    .status     (status)
  );

endmodule

// ==== rtl/bpi_fifo.sv ====
`timescale 1ns/10ps

module bpi_fifo #(
  parameter int FIFO_AW = 11
)
(
  input  logic               CLK,
  input  logic               local_rst,
  input  logic               wr,
  input  bpi_bus_pkg::word_t wdata,
  input  logic               rd,
  output bpi_bus_pkg::word_t rdata,
  output logic               empty,
  output logic               full,
  output logic [FIFO_AW:0]   count,
  output logic               wr_err,
  output logic               rd_err
);
  import bpi_bus_pkg::*;

  localparam int DEPTH = 2 ** FIFO_AW;

  word_t              mem [DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic               wr_ok;
  logic               rd_ok;

  assign empty = (count == '0);
  assign full  = count[FIFO_AW];       // Count reaches DEPTH only when full
  assign wr_ok = wr && !full;
  assign rd_ok = rd && !empty;
  assign rdata = mem[rd_ptr];          // Head word falls through

  always_ff @(posedge CLK)
  begin
    if (wr_ok)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      wr_err <= 1'b0;
      rd_err <= 1'b0;
    end
    else
    begin
      if (wr_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // Idle or both at once
      endcase
      wr_err <= wr && full;    // Dropped write
      rd_err <= rd && empty;   // Read of nothing
    end
  end

endmodule

// ==== rtl/bpi_sequencer.sv ====
`timescale 1ns/10ps

module bpi_sequencer
(
  input  logic                    CLK,
  input  logic                    local_rst,
  input  bpi_cmd_pkg::seq_req_t   req,
  input  logic                    req_valid,
  output logic                    req_ready,
  output logic                    seq_done,
  output bpi_bus_pkg::bpi_cycle_t cycle,
  output logic                    execute,
  input  bpi_bus_pkg::bpi_resp_t  resp,
  output logic                    rbk_wr,
  output logic [7:0]              sr_byte,
  output logic                    sr_valid
);
  import bpi_bus_pkg::*;
  import bpi_cmd_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_CYC1, S_CYC2, S_POLL, S_FINISH} seq_state_t;

  seq_state_t state;
  seq_req_t   op_q;
  read_mode_t mode;
  logic       launched;     // Execute sent for this bus cycle
  logic       busy_seen;    // Port has gone busy since
  logic       bus_done;
  logic       sr_load;
  logic       sr_ready;
  logic       ready_now;
  addr_t      bank_addr;
  addr_t      block_addr;

  assign req_ready = (state == S_IDLE);
  assign seq_done  = (state == S_FINISH);
  assign execute   = (state inside {S_CYC1, S_CYC2, S_POLL}) && !launched && !resp.busy;
  assign bus_done  = busy_seen && !resp.busy;

  assign bank_addr  = op_q.addr & BANK_MASK;
  assign block_addr = (op_q.addr >= PARAM_BLOCK_START) ? (op_q.addr & PARAM_BLOCK_MASK)
                                                       : (op_q.addr & MAIN_BLOCK_MASK);

  // Read data routing by mode
  assign rbk_wr    = resp.load_data && (state == S_CYC1) && (op_q.cmd == CMD_READ_1) &&
                     (mode == RD_ARRAY);
  assign sr_load   = resp.load_data && ((state == S_POLL) ||
                     ((state == S_CYC1) && (op_q.cmd == CMD_READ_1) && (mode == RD_STATUS)));
  assign ready_now = sr_load ? resp.data[SR_READY_BIT] : sr_ready;

  ////////////////////
  // Bus cycle contents
  always_comb
  begin
    cycle.op   = BPI_OP_WRITE;
    cycle.addr = bank_addr;
    cycle.data = '0;
    case (state)
      S_CYC1:
        case (op_q.cmd)
          CMD_READ_ARRAY:      cycle.data = OPC_READ_ARRAY;
          CMD_READ_STATUS_REG: cycle.data = OPC_READ_SR;
          CMD_READ_1:
          begin
            cycle.op   = BPI_OP_READ;
            cycle.addr = op_q.addr;
          end
          CMD_PROGRAM:
          begin
            cycle.addr = op_q.addr;
            cycle.data = OPC_PROGRAM;
          end
          default:
          begin
            cycle.addr = block_addr;    // Erase setup
            cycle.data = OPC_ERASE_SETUP;
          end
        endcase
      S_CYC2:
        if (op_q.cmd == CMD_PROGRAM)
        begin
          cycle.addr = op_q.addr;
          cycle.data = op_q.data;
        end
        else
        begin
          cycle.addr = block_addr;
          cycle.data = OPC_CONFIRM;
        end
      S_POLL:   cycle.op = BPI_OP_READ;   // Status read, any bank address
      default:  cycle.data = '0;
    endcase
  end

  ////////////////////
  // Sequencing FSM
  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      state     <= S_IDLE;
      mode      <= RD_ARRAY;     // PROM powers up in array mode
      launched  <= 1'b0;
      busy_seen <= 1'b0;
      sr_ready  <= 1'b0;
      sr_valid  <= 1'b0;
    end
    else
    begin
      sr_valid <= 1'b0;
      if (execute)
        launched <= 1'b1;
      if (launched && resp.busy)
        busy_seen <= 1'b1;
      if (bus_done)
      begin
        launched  <= 1'b0;
        busy_seen <= 1'b0;
      end
      if (sr_load)
        sr_ready <= resp.data[SR_READY_BIT];
      case (state)
        S_IDLE:
          if (req_valid)
            state <= S_CYC1;
        S_CYC1:
          if (bus_done)
          begin
            case (op_q.cmd)
              CMD_READ_ARRAY:      mode <= RD_ARRAY;
              CMD_READ_STATUS_REG: mode <= RD_STATUS;
              default:             mode <= mode;
            endcase
            if ((op_q.cmd == CMD_PROGRAM) || (op_q.cmd == CMD_BLOCK_ERASE))
              state <= S_CYC2;
            else
              state <= S_FINISH;
            sr_valid <= (op_q.cmd == CMD_READ_1) && (mode == RD_STATUS);
          end
        S_CYC2:
          if (bus_done)
          begin
            mode     <= RD_STATUS;
            sr_ready <= 1'b0;
            state    <= S_POLL;
          end
        S_POLL:
          if (bus_done && ready_now)
          begin
            sr_valid <= 1'b1;     // Final status of the operation
            state    <= S_FINISH;
          end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (req_valid && req_ready)
      op_q <= req;
    if (sr_load)
      sr_byte <= resp.data[7:0];
  end

endmodule

// ==== rtl/bpi_status_reg.sv ====
`timescale 1ns/10ps

module bpi_status_reg
(
  input  logic               CLK,
  input  logic               local_rst,
  input  logic               rbk_empty,
  input  logic               rbk_full,
  input  logic               rbk_rd_err,
  input  logic               rbk_wr_err,
  input  logic               cmd_empty,
  input  logic               cmd_full,
  input  logic               cmd_rd_err,
  input  logic               cmd_wr_err,
  input  logic [7:0]         sr_byte,
  input  logic               sr_valid,
  input  logic               clr_status,
  output bpi_bus_pkg::word_t status
);
  import bpi_cmd_pkg::*;

  // PROM error bits dropped by a clear, bits 5, 4, 3 and 1
  localparam logic [7:0] SR_CLR_MASK = ERASE_ERR_MASK | PROG_ERR_MASK;

  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
      status <= '0;
    else
    begin
      status[ST_RBK_EMPTY] <= rbk_empty;
      status[ST_RBK_FULL]  <= rbk_full;
      status[ST_RBK_RERR]  <= !clr_status && (status[ST_RBK_RERR] || rbk_rd_err);  // Sticky
      status[ST_RBK_WERR]  <= !clr_status && (status[ST_RBK_WERR] || rbk_wr_err);
      status[ST_CMD_EMPTY] <= cmd_empty;
      status[ST_CMD_FULL]  <= cmd_full;
      status[ST_CMD_RERR]  <= !clr_status && (status[ST_CMD_RERR] || cmd_rd_err);
      status[ST_CMD_WERR]  <= !clr_status && (status[ST_CMD_WERR] || cmd_wr_err);
      if (sr_valid)
        status[7:0] <= sr_byte;
      else if (clr_status)
        status[7:0] <= status[7:0] & ~SR_CLR_MASK;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the BPI controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_bpi_ctrl \
  -f compile.f -o sim_bpi > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/sim_bpi > sim.log 2>&1
run_status=$?
cat sim.log

if grep -qF "*** FAILED ***" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0

// ==== tests/bpi_checker.sv ====
`timescale 1ns/10ps

module bpi_checker #(
  parameter int CW = 5
)
(
  input bpi_bus_pkg::word_t rbk_data,
  input logic [CW-1:0]      rbk_wrd_cnt,
  input bpi_bus_pkg::word_t status,
  input logic               execute,
  input logic               active
);
  import bpi_bus_pkg::*;

  int error_count = 0;
  int test_count  = 0;
  int test_errors = 0;
  int failed_tests = 0;

  task automatic compare_value(input string sig, input word_t exp, input word_t act);
    if (exp !== act)
    begin
      $display("Error at %0t: %s expected %h, got %h", $time, sig, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  ////////////////////
  // Checks called from the stimulus loop at a falling edge
  task automatic check_word(input word_t exp);
    compare_value("rbk_data", exp, rbk_data);
  endtask

  task automatic check_count(input int exp);
    compare_value("rbk_wrd_cnt", word_t'(exp), word_t'(rbk_wrd_cnt));
  endtask

  task automatic check_status(input word_t mask, input word_t exp);
    compare_value("status", exp & mask, status & mask);   // Only the bits under test
  endtask

  task automatic check_bus_idle();
    compare_value("execute", 16'h0000, {15'h0000, execute});
  endtask

  task automatic check_active(input logic exp);
    compare_value("active", {15'h0000, exp}, {15'h0000, active});
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (test_errors == 0)
      $display("Test %0d (%s): ok", test_count, name);
    else
    begin
      $display("Test %0d (%s): %0d error(s)", test_count, name, test_errors);
      failed_tests++;
    end
    test_errors = 0;
  endtask

  task automatic report_totals();
    $display("Tests run: %0d, failed: %0d, errors: %0d", test_count, failed_tests,
             error_count);
  endtask

endmodule

// ==== tests/bpi_sequencer_asserts.sv ====
`timescale 1ns/10ps

module bpi_sequencer_asserts
(
  input logic                    CLK,
  input logic                    local_rst,
  input logic                    execute,
  input logic                    busy,
  input logic                    launched,
  input logic                    bus_done,
  input bpi_bus_pkg::bpi_cycle_t cycle
);

  logic in_flight;   // Launched and not yet finished by the port
  logic went_busy;

  ////////////////////
  // Port side view of an outstanding bus cycle
  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      in_flight <= 1'b0;
      went_busy <= 1'b0;
    end
    else if (execute)
    begin
      in_flight <= 1'b1;
      went_busy <= 1'b0;
    end
    else if (in_flight && busy)
      went_busy <= 1'b1;
    else if (went_busy)
    begin
      in_flight <= 1'b0;     // Busy has fallen again
      went_busy <= 1'b0;
    end
  end

  // Single-cycle launch pulse
  exec_pulse_a: assert property (@(posedge CLK) disable iff (local_rst)
    execute |=> !execute)
    else $error("execute stayed high for more than one cycle");

  // No launch while the port is busy or a cycle is still outstanding
  exec_not_busy_a: assert property (@(posedge CLK) disable iff (local_rst)
    execute |-> (!busy && !in_flight))
    else $error("execute issued while the port was busy or a cycle was pending");

  // Bus cycle held from launch until the port finishes
  cycle_stable_a: assert property (@(posedge CLK) disable iff (local_rst)
    (execute || (launched && !bus_done)) |=> $stable(cycle))
    else $error("bus cycle changed while a cycle was pending");

endmodule

bind bpi_sequencer bpi_sequencer_asserts bpi_sequencer_asserts_i (
  .CLK       (CLK),
  .local_rst (local_rst),
  .execute   (execute),
  .busy      (resp.busy),
  .launched  (launched),
  .bus_done  (bus_done),
  .cycle     (cycle)
);

// ==== tests/tb_bpi_ctrl.sv ====
`timescale 1ns/10ps

module tb_bpi_ctrl;
  import bpi_bus_pkg::*;

  localparam int    FIFO_AW   = 4;
  localparam int    NT        = 8;            // Table entries
  localparam int    MAX_CYC   = NT * 500;
  localparam addr_t FLAG_ADDR = 23'h100040;   // Program here fails

  logic              CLK = 1'b0;
  logic              local_rst = 1'b1;
  word_t             cmd_data;
  logic              cmd_we;
  logic              rbk_re;
  logic              enbl;
  logic              dsbl;
  word_t             rbk_data;
  logic [FIFO_AW:0]  rbk_wrd_cnt;
  word_t             status;
  logic              active;
  bpi_cycle_t        cycle;
  logic              execute;
  bpi_resp_t         resp;

  // Stimulus table in flat arrays
  string  t_name [NT];
  bit     t_dis [NT];          // Words go in while parsing is off
  bit     t_erd [NT];          // Read from an empty readback first
  word_t  t_mask [NT];
  word_t  t_val [NT];
  int     cmd_first [NT];
  int     cmd_num [NT];
  int     rbk_first [NT];
  int     rbk_num [NT];
  word_t  cmd_list [$];
  word_t  rbk_list [$];
  int     cur = -1;
  int     cyc_cnt = 0;

  always #4 CLK = !CLK;

  bpi_ctrl #(.FIFO_AW(FIFO_AW)) bpi_ctrl_i (
    .CLK         (CLK),
    .local_rst   (local_rst),
    .cmd_data    (cmd_data),
    .cmd_we      (cmd_we),
    .rbk_re      (rbk_re),
    .enbl        (enbl),
    .dsbl        (dsbl),
    .rbk_data    (rbk_data),
    .rbk_wrd_cnt (rbk_wrd_cnt),
    .status      (status),
    .active      (active),
    .cycle       (cycle),
    .execute     (execute),
    .resp        (resp)
  );

  bpi_checker #(.CW(FIFO_AW + 1)) checker_i (
    .rbk_data    (rbk_data),
    .rbk_wrd_cnt (rbk_wrd_cnt),
    .status      (status),
    .execute     (execute),
    .active      (active)
  );

  ////////////////////
  // PROM model
  word_t      prom_mem [addr_t];
  bpi_cycle_t cyc_q;
  logic       prom_busy = 1'b0;
  logic       prom_load = 1'b0;
  word_t      prom_dout = '0;
  logic       start_pend = 1'b0;
  int         busy_left = 0;
  bit         prom_status_mode = 1'b0;
  logic [7:0] prom_sr = 8'h80;
  bit         pend_prog = 1'b0;
  bit         pend_erase = 1'b0;
  int         polls_left = 0;    // Polls still reporting not ready

  assign resp = '{busy: prom_busy, load_data: prom_load, data: prom_dout};

  function automatic word_t mem_read(input addr_t a);
    return prom_mem.exists(a) ? prom_mem[a] : 16'hFFFF;
  endfunction

  task automatic erase_block(input addr_t a);
    addr_t mask;
    addr_t k;
    addr_t hits [$];
    mask = (a >= 23'h7F0000) ? 23'h7FC000 : 23'h7F0000;  // Small top blocks
    if (prom_mem.first(k))
    begin
      do
        if ((k & mask) == (a & mask))
          hits.push_back(k);
      while (prom_mem.next(k));
    end
    foreach (hits[i])
      prom_mem.delete(hits[i]);
  endtask

  task automatic finish_cycle();
    if (cyc_q.op == BPI_OP_READ)
    begin
      prom_load <= 1'b1;
      if (!prom_status_mode)
        prom_dout <= mem_read(cyc_q.addr);
      else if (polls_left > 0)
      begin
        polls_left--;
        prom_dout <= {8'h00, prom_sr & 8'h7F};   // Still busy
      end
      else
        prom_dout <= {8'h00, prom_sr};
    end
    else if (pend_prog)
    begin
      pend_prog = 1'b0;
      if (cyc_q.addr == FLAG_ADDR)
        prom_sr = 8'h90;                         // Program failure
      else
      begin
        prom_mem[cyc_q.addr] = cyc_q.data;
        prom_sr = 8'h80;
      end
      polls_left = 1;
    end
    else if (pend_erase)
    begin
      pend_erase = 1'b0;
      if (cyc_q.data[7:0] == 8'hD0)
        erase_block(cyc_q.addr);
      prom_sr = 8'h80;
      polls_left = 1;
    end
    else
      case (cyc_q.data[7:0])
        8'hFF: prom_status_mode = 1'b0;
        8'h70: prom_status_mode = 1'b1;
        8'h40:
        begin
          pend_prog = 1'b1;
          prom_status_mode = 1'b1;
        end
        8'h20:
        begin
          pend_erase = 1'b1;
          prom_status_mode = 1'b1;
        end
        default: prom_status_mode = prom_status_mode;
      endcase
  endtask

  always @(negedge CLK)
  begin
    if (local_rst)
    begin
      prom_busy  <= 1'b0;
      prom_load  <= 1'b0;
      start_pend <= 1'b0;
    end
    else
    begin
      prom_load <= 1'b0;
      if (start_pend)
      begin
        prom_busy  <= 1'b1;         // Goes busy once execute is taken
        start_pend <= 1'b0;
        busy_left  = 2 + int'($urandom % 5);
      end
      else if (prom_busy)
      begin
        if (busy_left > 1)
          busy_left--;
        else
        begin
          prom_busy <= 1'b0;
          finish_cycle();
        end
      end
      else if (execute)
      begin
        cyc_q      = cycle;
        start_pend <= 1'b1;
      end
    end
  end

  ////////////////////
  // Table and stimulus
  task automatic add_test(input string name, input bit dis, input bit erd,
                          input word_t mask, input word_t val);
    cur++;
    t_name[cur]    = name;
    t_dis[cur]     = dis;
    t_erd[cur]     = erd;
    t_mask[cur]    = mask;
    t_val[cur]     = val;
    cmd_first[cur] = cmd_list.size();
    cmd_num[cur]   = 0;
    rbk_first[cur] = rbk_list.size();
    rbk_num[cur]   = 0;
  endtask

  task automatic add_cmd(input word_t w);
    cmd_list.push_back(w);
    cmd_num[cur]++;
  endtask

  task automatic add_exp(input word_t w);
    rbk_list.push_back(w);
    rbk_num[cur]++;
  endtask

  task automatic build_table();
    add_test("reset state", 0, 0, 16'hFFFF, 16'h8800);
    add_test("program and read back", 0, 0, 16'hC0FF, 16'h0080);
    add_cmd(16'h0217);   // Base 10, offset 0020
    add_cmd(16'h0020);
    add_cmd(16'h000B);
    add_cmd(16'hA5C3);
    add_cmd(16'h000B);
    add_cmd(16'h3C5A);
    add_cmd(16'h0005);
    add_cmd(16'h0217);
    add_cmd(16'h0020);
    add_cmd(16'h0002);
    add_cmd(16'h0002);
    add_exp(16'hA5C3);
    add_exp(16'h3C5A);
    add_test("parameter block erase", 0, 0, 16'hC0FF, 16'h0080);
    add_cmd(16'h0FF7);   // Base 7F
    add_cmd(16'h4010);
    add_cmd(16'h000A);
    add_cmd(16'h0005);
    add_cmd(16'h0FF7);
    add_cmd(16'h4020);
    add_cmd(16'h0002);
    add_cmd(16'h0FF7);   // Next 16 KWord block
    add_cmd(16'h8010);
    add_cmd(16'h0002);
    add_exp(16'hFFFF);
    add_exp(16'h8888);
    add_test("parse disabled then enabled", 1, 0, 16'hC000, 16'h0000);
    add_cmd(16'h0217);
    add_cmd(16'h0020);
    add_cmd(16'h0002);
    add_cmd(16'h0002);
    add_exp(16'hA5C3);
    add_exp(16'h3C5A);
    add_test("program error status", 0, 0, 16'h00FF, 16'h0090);
    add_cmd(16'h0217);
    add_cmd(16'h0040);
    add_cmd(16'h000B);
    add_cmd(16'hBEEF);
    add_cmd(16'h0006);
    add_cmd(16'h0002);
    add_test("clear PROM error bits", 0, 0, 16'h00FF, 16'h0080);
    add_cmd(16'h001C);
    add_test("readback underflow and overflow", 0, 1, 16'hF000, 16'h7000);
    add_cmd(16'h0005);
    add_cmd(16'h0417);   // Base 20
    add_cmd(16'h0000);
    for (int i = 0; i < 17; i++)
      add_cmd(16'h0002);
    for (int i = 0; i < 16; i++)
      add_exp(16'hFFFF);                    // 17th read is dropped
    add_test("clear FIFO errors", 0, 0, 16'hFF00, 16'h8800);
    add_cmd(16'h001C);
  endtask

  task automatic pulse(ref logic sig);
    sig = 1'b1;
    @(negedge CLK);
    sig = 1'b0;
  endtask

  task automatic push_word(input word_t w);
    cmd_data = w;
    pulse(cmd_we);
    repeat (2) @(negedge CLK);
    while (status[10])           // Command FIFO full
      @(negedge CLK);
  endtask

  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < 3)
    begin
      @(negedge CLK);
      if (status[11] && !active)
        quiet++;
      else
        quiet = 0;
    end
  endtask

  task automatic run_test(input int t);
    if (t_erd[t])
      pulse(rbk_re);
    if (t_dis[t])
      pulse(dsbl);
    else
      pulse(enbl);
    for (int i = 0; i < cmd_num[t]; i++)
      push_word(cmd_list[cmd_first[t] + i]);
    if (t_dis[t])
    begin
      repeat (20) @(negedge CLK);
      checker_i.check_count(0);
      checker_i.check_status(16'h0800, 16'h0000);   // Words still queued
      checker_i.check_active(1'b0);                 // Parser held in idle
      pulse(enbl);
    end
    wait_idle();
    checker_i.check_count(rbk_num[t]);
    checker_i.check_status(t_mask[t], t_val[t]);
    checker_i.check_bus_idle();
    for (int i = 0; i < rbk_num[t]; i++)
    begin
      checker_i.check_word(rbk_list[rbk_first[t] + i]);
      pulse(rbk_re);
    end
    checker_i.check_count(0);
    checker_i.end_test(t_name[t]);
  endtask

  always @(posedge CLK)
  begin
    cyc_cnt++;
    if (cyc_cnt >= MAX_CYC)
    begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'h7f75_8c4a));
    cmd_data = '0;
    cmd_we   = 1'b0;
    rbk_re   = 1'b0;
    enbl     = 1'b0;
    dsbl     = 1'b0;
    prom_mem[23'h7F4020] = 16'h2222;   // Same block as the erase
    prom_mem[23'h7F8010] = 16'h8888;
    build_table();
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    local_rst = 1'b0;
    @(negedge CLK);
    for (int t = 0; t <= cur; t++)
      run_test(t);
    checker_i.report_totals();
    if (checker_i.error_count == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule
